//--- src/common_pkg.sv
// core-wide data types

package common_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] vaddr_t;

    // one data word, seen either as four byte lanes or as two half lanes.
    // lane 0 is always the least significant part of the word.
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lane_word_t;

endpackage

//--- src/mem_pkg.sv
// memory operation definitions

package mem_pkg;

    // decoded memory operation as handed to the load/store unit.
    typedef enum logic [3:0] {
        OP_NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } decoded_op_t;

    // one bit per byte lane of the data word.
    typedef logic [3:0] strobe_t;

    localparam int MEM_WORDS     = 256;
    localparam int MEM_ADDR_BITS = 8; // word index width, log2 of MEM_WORDS.

endpackage

//--- src/mem_port_if.sv
// agu to data ram port

`timescale 1ns/10ps

interface mem_port_if;

    import common_pkg::*;
    import mem_pkg::*;

    logic [MEM_ADDR_BITS-1:0] word_index;
    strobe_t                  wstrb; // nonzero on a request means a write.
    word_t                    wdata;
    logic                     req;
    word_t                    rdata; // valid the cycle after req.

    modport agu_mp (
        output word_index,
        output wstrb,
        output wdata,
        output req,
        input  rdata
    );

    modport ram_mp (
        input  word_index,
        input  wstrb,
        input  wdata,
        input  req,
        output rdata
    );

endinterface

//--- src/store_align.sv
// store lane alignment

`timescale 1ns/10ps

module store_align (
    input  logic [1:0]           offset,
    input  mem_pkg::decoded_op_t op,
    input  common_pkg::word_t    store_data,
    output mem_pkg::strobe_t     wstrb,
    output common_pkg::word_t    wdata
);

    import common_pkg::*;
    import mem_pkg::*;

    logic [4:0] byte_shift;

    assign byte_shift = {offset, 3'b000}; // offset in bits.

    always_comb begin
        wstrb = '0;
        wdata = '0;
        case (op)
            SB: begin
                wstrb = strobe_t'(4'b0001 << offset);
                wdata = {{(XLEN-8){1'b0}}, store_data[7:0]} << byte_shift;
            end
            SH: begin
                // only offset bit 1 matters here, bit 0 set is a misaligned access.
                if (offset[1]) begin
                    wstrb = 4'b1100;
                    wdata = {store_data[15:0], 16'h0000};
                end else begin
                    wstrb = 4'b0011;
                    wdata = {16'h0000, store_data[15:0]};
                end
            end
            SW: begin
                wstrb = 4'b1111;
                wdata = store_data;
            end
            default: begin
                wstrb = '0; // loads and non-memory ops write nothing.
                wdata = '0;
            end
        endcase
    end

endmodule

//--- src/load_align.sv
// load lane extraction

`timescale 1ns/10ps

module load_align (
    input  logic [1:0]           offset,
    input  mem_pkg::decoded_op_t op,
    input  common_pkg::word_t    rdata,
    output common_pkg::word_t    load_data
);

    import common_pkg::*;
    import mem_pkg::*;

    lane_word_t  lanes;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign lanes    = lane_word_t'(rdata);
    assign sel_byte = lanes.bytes[offset];
    assign sel_half = lanes.halves[offset[1]]; // bit 0 is zero for an aligned half.

    always_comb begin
        case (op)
            LB: begin
                load_data = {{(XLEN-8){sel_byte[7]}}, sel_byte};
            end
            LBU: begin
                load_data = {{(XLEN-8){1'b0}}, sel_byte};
            end
            LH: begin
                load_data = {{(XLEN-16){sel_half[15]}}, sel_half};
            end
            LHU: begin
                load_data = {{(XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                // LW takes the whole word.
                load_data = rdata;
            end
        endcase
    end

endmodule

//--- src/agu.sv
// address generation unit

`timescale 1ns/10ps

module agu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  mem_pkg::decoded_op_t op,
    input  common_pkg::word_t    src1,
    input  common_pkg::word_t    src2,
    input  common_pkg::word_t    store_data,
    mem_port_if.agu_mp           mem,
    output common_pkg::word_t    load_data,
    output logic                 load_valid,
    output logic                 misaligned
);

    import common_pkg::*;
    import mem_pkg::*;

    vaddr_t      addr;
    logic        is_load;
    logic        is_store;
    logic        is_half;
    logic        is_word;
    logic        bad_align;
    logic        access;
    logic        go;
    strobe_t     st_wstrb;
    word_t       st_wdata;
    decoded_op_t load_op_q;
    logic [1:0]  load_offset_q;

    assign addr = src1 + src2;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op)
            LB, LBU: begin
                is_load = 1'b1;
            end
            LH, LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            SB: begin
                is_store = 1'b1;
            end
            SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    assign bad_align = (is_half & addr[0]) | (is_word & (addr[1:0] != 2'b00));
    assign access    = valid & (is_load | is_store);
    assign go        = access & ~bad_align; // misaligned accesses never reach the ram.

    store_align store_align_i (
        .offset     (addr[1:0]),
        .op         (op),
        .store_data (store_data),
        .wstrb      (st_wstrb),
        .wdata      (st_wdata)
    );

    assign mem.req        = go;
    assign mem.word_index = addr[MEM_ADDR_BITS+1:2];
    assign mem.wstrb      = go ? st_wstrb : '0;
    assign mem.wdata      = st_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            load_valid <= go & is_load;
            misaligned <= access & bad_align;
        end
    end

    // the lane selection must line up with the rdata that comes back next cycle.
    always_ff @(posedge clk) begin
        if (go & is_load) begin
            load_op_q     <= op;
            load_offset_q <= addr[1:0];
        end
    end

    load_align load_align_i (
        .offset    (load_offset_q),
        .op        (load_op_q),
        .rdata     (mem.rdata),
        .load_data (load_data)
    );

endmodule

//--- src/data_ram.sv
// byte-strobed data ram

`timescale 1ns/10ps

module data_ram (
    input logic        clk,
    mem_port_if.ram_mp mem
);

    import common_pkg::*;
    import mem_pkg::*;

    word_t ram [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem.req) begin
            for (int lane = 0; lane < $bits(strobe_t); lane++) begin
                if (mem.wstrb[lane]) begin
                    ram[mem.word_index][lane*8 +: 8] <= mem.wdata[lane*8 +: 8];
                end
            end
            // the read sees the word as it was before this write.
            mem.rdata <= ram[mem.word_index];
        end
    end

endmodule

//--- src/lsu_top.sv
// load/store unit top

`timescale 1ns/10ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  mem_pkg::decoded_op_t op,
    input  common_pkg::word_t    src1,
    input  common_pkg::word_t    src2,
    input  common_pkg::word_t    store_data,
    output common_pkg::word_t    load_data,
    output logic                 load_valid,
    output logic                 misaligned
);

    mem_port_if mem_bus ();

    agu agu_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .store_data (store_data),
        .mem        (mem_bus),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    data_ram data_ram_i (
        .clk (clk),
        .mem (mem_bus)
    );

endmodule

//--- sim/lsu_checker.sv
// load/store unit protocol checks

`timescale 1ns/10ps

module lsu_checker (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic load_valid,
    input logic misaligned
);

    int error_count = 0; // number of assertion failures so far.

    // a request either completes as a load or is flagged, never both.
    no_double_response: assert property (@(posedge clk) disable iff (rst)
        !(load_valid && misaligned))
        else begin
            $error("load_valid and misaligned are high in the same cycle");
            error_count++;
        end

    // every response cycle must have its own request one cycle earlier.
    load_needs_request: assert property (@(posedge clk) disable iff (rst)
        load_valid |-> $past(valid))
        else begin
            $error("load_valid is high without a request in the previous cycle");
            error_count++;
        end

    misaligned_needs_request: assert property (@(posedge clk) disable iff (rst)
        misaligned |-> $past(valid))
        else begin
            $error("misaligned is high without a request in the previous cycle");
            error_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> (!load_valid && !misaligned))
        else begin
            $error("an output is high in the cycle after reset");
            error_count++;
        end

endmodule

//--- sim/lsu_tb.sv
// load/store unit testbench

`timescale 1ns/10ps

module lsu_tb;

    import common_pkg::*;
    import mem_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ENTRIES = 36;
    localparam logic [31:0] LFSR_SEED = 32'h55bc_a911;

    // rnd replaces data with lfsr bits.
    typedef struct packed {
        logic        valid;
        decoded_op_t op;
        word_t       src1;
        word_t       src2;
        word_t       data;
        logic        rnd;
    } entry_t;

    localparam entry_t stim_table [NUM_ENTRIES] = '{
        '{1'b0, OP_NONE, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0},
        '{1'b1, SW,  32'h0000_0030, 32'h10, 32'h8c3a_71f5, 1'b0}, // lanes f5 71 3a 8c.
        '{1'b1, LW,  32'h0000_003c, 32'h04, 32'h0000_0000, 1'b0},
        '{1'b1, LB,  32'h0000_0040, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, LBU, 32'h0000_0040, 32'h01, 32'h0000_0000, 1'b0},
        '{1'b1, LB,  32'h0000_0041, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, LBU, 32'h0000_0042, 32'h01, 32'h0000_0000, 1'b0},
        '{1'b1, LH,  32'h0000_0020, 32'h20, 32'h0000_0000, 1'b0},
        '{1'b1, LHU, 32'h0000_0040, 32'h02, 32'h0000_0000, 1'b0},
        '{1'b1, LH,  32'h0000_0041, 32'h01, 32'h0000_0000, 1'b0},
        '{1'b1, LHU, 32'h0000_003e, 32'h02, 32'h0000_0000, 1'b0},
        '{1'b1, SW,  32'h0000_0080, 32'h00, 32'h0000_0000, 1'b1},
        '{1'b1, SB,  32'h0000_0080, 32'h00, 32'h1234_56a5, 1'b0},
        '{1'b1, LW,  32'h0000_0070, 32'h10, 32'h0000_0000, 1'b0},
        '{1'b1, SB,  32'h0000_0080, 32'h01, 32'h0000_005b, 1'b0},
        '{1'b1, SB,  32'h0000_0081, 32'h01, 32'hffff_ffc6, 1'b0},
        '{1'b1, SB,  32'h0000_0080, 32'h03, 32'h0000_001d, 1'b0},
        '{1'b1, LW,  32'h0000_0080, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, SH,  32'h0000_0080, 32'h02, 32'h0000_e4d2, 1'b0},
        '{1'b1, LW,  32'h0000_0078, 32'h08, 32'h0000_0000, 1'b0},
        '{1'b1, SH,  32'h0000_0040, 32'h40, 32'h0000_0000, 1'b1},
        '{1'b1, LW,  32'h0000_0080, 32'h00, 32'h0000_0000, 1'b0}, // same word right after.
        '{1'b0, LW,  32'h0000_0080, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, OP_NONE, 32'h0000_0080, 32'h0, 32'h0000_0000, 1'b0},
        '{1'b1, LH,  32'h0000_0080, 32'h01, 32'h0000_0000, 1'b0},
        '{1'b1, LHU, 32'h0000_0080, 32'h03, 32'h0000_0000, 1'b0},
        '{1'b1, SH,  32'h0000_0080, 32'h01, 32'hffff_ffff, 1'b0},
        '{1'b1, LW,  32'h0000_0080, 32'h02, 32'h0000_0000, 1'b0},
        '{1'b1, SW,  32'h0000_0081, 32'h02, 32'hdead_beef, 1'b0},
        '{1'b1, LW,  32'h0000_0080, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, SW,  32'h0000_00b0, 32'h10, 32'h0000_0000, 1'b1},
        '{1'b1, LW,  32'h0000_00c0, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b1, SB,  32'h0000_00c0, 32'h02, 32'h0000_0000, 1'b1},
        '{1'b1, LBU, 32'h0000_00c1, 32'h01, 32'h0000_0000, 1'b0},
        '{1'b1, LW,  32'h0000_00c0, 32'h00, 32'h0000_0000, 1'b0},
        '{1'b0, OP_NONE, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0}
    };

    logic        clk;
    logic        rst;
    logic        valid;
    decoded_op_t op;
    word_t       src1;
    word_t       src2;
    word_t       store_data;
    word_t       load_data;
    logic        load_valid;
    logic        misaligned;

    logic [31:0] lfsr_state;
    logic [7:0]  model_mem [MEM_WORDS*4]; // byte image of the data ram.
    logic        exp_lv;
    logic        exp_mis;
    word_t       exp_data;

    lsu_top lsu_top_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    bind lsu_top lsu_checker lsu_checker_i (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .load_valid (load_valid),
        .misaligned (misaligned)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val[i] = lfsr_state[0];
        end
    endtask

    function automatic logic misaligned_access(input decoded_op_t o, input vaddr_t addr);
        case (o)
            LH, LHU, SH: return addr[0];
            LW, SW:      return addr[1:0] != 2'b00;
            default:     return 1'b0;
        endcase
    endfunction

    // applies one request to the model and gives the outputs of the next cycle.
    task automatic predict(input logic v, input decoded_op_t o, input vaddr_t addr,
                           input word_t d, output logic lv, output logic mis, output word_t ld);
        logic [MEM_ADDR_BITS+1:0] b;
        logic [15:0]              half;
        b    = addr[MEM_ADDR_BITS+1:0];
        half = {model_mem[b+1], model_mem[b]}; // little endian.
        lv   = 1'b0;
        ld   = '0;
        mis  = v && misaligned_access(o, addr);
        if (v && !mis) begin
            case (o)
                LB:  ld = {{24{model_mem[b][7]}}, model_mem[b]};
                LBU: ld = {24'h0, model_mem[b]};
                LH:  ld = {{16{half[15]}}, half};
                LHU: ld = {16'h0, half};
                LW:  ld = {model_mem[b+3], model_mem[b+2], model_mem[b+1], model_mem[b]};
                SB:  model_mem[b] = d[7:0];
                SH: begin
                    model_mem[b]   = d[7:0];
                    model_mem[b+1] = d[15:8];
                end
                SW: begin
                    for (int k = 0; k < 4; k++) begin
                        model_mem[b+k] = d[k*8 +: 8];
                    end
                end
                default: ld = '0;
            endcase
            lv = o inside {LB, LBU, LH, LHU, LW};
        end
    endtask

    task automatic report_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_outputs(input int idx);
        assert (load_valid === exp_lv) else
            report_failure($sformatf("entry %0d load_valid %b, expected %b",
                                     idx, load_valid, exp_lv));
        assert (misaligned === exp_mis) else
            report_failure($sformatf("entry %0d misaligned %b, expected %b",
                                     idx, misaligned, exp_mis));
        if (exp_lv) begin
            assert (load_data === exp_data) else
                report_failure($sformatf("entry %0d load_data %h, expected %h",
                                         idx, load_data, exp_data));
        end
    endtask

    initial begin
        #((NUM_ENTRIES + 10) * CLK_PERIOD);
        $display("timeout, the test table did not finish in time");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        wait (lsu_top_i.lsu_checker_i.error_count != 0);
        $display("a protocol assertion on the outputs failed");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        entry_t e;
        word_t  split;
        word_t  a1;
        word_t  a2;
        word_t  d;
        logic   nxt_lv;
        logic   nxt_mis;
        word_t  nxt_data;
        clk        = 1'b0;
        rst        = 1'b1;
        valid      = 1'b0;
        op         = OP_NONE;
        src1       = '0;
        src2       = '0;
        store_data = '0;
        lfsr_state = LFSR_SEED;
        exp_lv     = 1'b0;
        exp_mis    = 1'b0;
        exp_data   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            e = stim_table[i];
            take_bits(8, split); // the address sum stays the same.
            a1 = e.src1 + split;
            a2 = e.src2 - split;
            d  = e.data;
            if (e.rnd) begin
                take_bits(32, d);
            end
            valid      <= e.valid;
            op         <= e.op;
            src1       <= a1;
            src2       <= a2;
            store_data <= d;
            predict(e.valid, e.op, a1 + a2, d, nxt_lv, nxt_mis, nxt_data);
            @(negedge clk);
            check_outputs(i - 1);
            exp_lv   = nxt_lv;
            exp_mis  = nxt_mis;
            exp_data = nxt_data;
        end
        @(posedge clk);
        valid <= 1'b0;
        op    <= OP_NONE;
        @(negedge clk);
        check_outputs(NUM_ENTRIES - 1);
        $display("sim passed");
        $finish;
    end

endmodule

//--- lsu.f
src/common_pkg.sv
src/mem_pkg.sv
src/mem_port_if.sv
src/store_align.sv
src/load_align.sv
src/agu.sv
src/data_ram.sv
src/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - src/common_pkg.sv
  - src/mem_pkg.sv
  - src/mem_port_if.sv
  - src/store_align.sv
  - src/load_align.sv
  - src/agu.sv
  - src/data_ram.sv
  - src/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_checker.sv
      - sim/lsu_tb.sv
